// File: verilog.f
verilog/video_pkg.sv
verilog/timing_pkg.sv
verilog/source_capture.sv
verilog/frame_store.sv
verilog/vga_timing_gen.sv
verilog/scale_address_gen.sv
verilog/pixel_output.sv
verilog/upscaler_top.sv
sim/upscaler_properties.sv
sim/upscaler_tb.sv

// File: sim/upscaler_tb.sv
module upscaler_tb;

	typedef enum logic [1:0] {pat_const, pat_col_ramp, pat_row_ramp, pat_random} pattern_e;

	// One table row, pattern plus expected blank colour
	typedef struct packed {
		pattern_e          kind;
		video_pkg::pixel_t colour;
		video_pkg::pixel_t blank_rgb;
	} case_t;

	localparam int num_cases = 5;
	localparam int wait_limit = 2000;

	// Two random frames in a row, second must replace the first
	case_t cases [num_cases] = '{
		'{pat_const, 12'ha5c, 12'h000},
		'{pat_col_ramp, 12'h009, 12'h000},
		'{pat_row_ramp, 12'h060, 12'h000},
		'{pat_random, 12'h000, 12'h000},
		'{pat_random, 12'h000, 12'h000}
	};

	logic              pixel_clk;
	logic              rst;
	video_pkg::video_t source_in;
	logic              pixel_strobe;
	video_pkg::video_t video_out;

	// Reference copy of the last source frame
	video_pkg::pixel_t model [timing_pkg::src_height][timing_pkg::src_width];
	logic [31:0] rand_state = 32'hc053;

	upscaler_top dut_i (
		.pixel_clk    (pixel_clk),
		.rst          (rst),
		.source_in    (source_in),
		.pixel_strobe (pixel_strobe),
		.video_out    (video_out)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #10 pixel_clk = ~pixel_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("error at time %0t: %s", $time, msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	// One strobed sample, strobe every second cycle
	task automatic send_sample(input video_pkg::video_t sample);
		@(negedge pixel_clk);
		source_in = sample;
		pixel_strobe = 1'b1;
		@(negedge pixel_clk);
		pixel_strobe = 1'b0;
	endtask

	task automatic send_frame(input case_t tc);
		video_pkg::video_t s;
		logic [3:0] c;
		logic [3:0] r;
		// Top of frame, vsync inside vblank
		for (int i = 0; i < 3; i++) begin
			s = '0;
			s.vblank = 1'b1;
			s.vsync = (i == 1);
			send_sample(s);
		end
		for (int row = 0; row < timing_pkg::src_height; row++) begin
			for (int col = 0; col < timing_pkg::src_width; col++) begin
				c = col[3:0];
				r = row[3:0];
				s = '0;
				case (tc.kind)
					pat_const: s.pixel = tc.colour;
					pat_col_ramp: s.pixel = {c, ~c, tc.colour.blue};
					pat_row_ramp: s.pixel = {r, tc.colour.green, ~r};
					default: begin
						rand_state = lcg_next(rand_state);
						s.pixel = rand_state[27:16];
					end
				endcase
				model[row][col] = s.pixel;
				send_sample(s);
			end
			// Line end, hsync inside hblank
			for (int i = 0; i < 3; i++) begin
				s = '0;
				s.hblank = 1'b1;
				s.hsync = (i == 1);
				send_sample(s);
			end
		end
		// Source idles in vblank
		source_in = '0;
		source_in.vblank = 1'b1;
	endtask

	task automatic wait_vblank_fall;
		int cycles;
		logic prev;
		logic seen;
		cycles = 0;
		prev = 1'b0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge pixel_clk);
			seen = prev && !video_out.vblank;
			prev = video_out.vblank;
			cycles++;
			if (cycles > wait_limit) begin
				$display("timeout: output vblank never fell within %0d cycles", wait_limit);
				$display("Test failures found");
				$fatal(1);
			end
		end
	endtask

	// Starts on the sample at output position 0,0
	task automatic check_frame(input case_t tc);
		video_pkg::video_t exp;
		int h;
		int v;
		for (v = 0; v < timing_pkg::out_v_total; v++) begin
			for (h = 0; h < timing_pkg::out_h_total; h++) begin
				if (v != 0 || h != 0)
					@(negedge pixel_clk);
				exp = '0;
				exp.hblank = (h >= timing_pkg::out_h_active);
				exp.vblank = (v >= timing_pkg::out_v_active);
				exp.hsync = (h >= timing_pkg::out_h_active + timing_pkg::out_h_front) &&
					(h < timing_pkg::out_h_active + timing_pkg::out_h_front +
					timing_pkg::out_h_sync);
				exp.vsync = (v >= timing_pkg::out_v_active + timing_pkg::out_v_front) &&
					(v < timing_pkg::out_v_active + timing_pkg::out_v_front +
					timing_pkg::out_v_sync);
				// Nearest source pixel from the Q12 steps
				if (!exp.hblank && !exp.vblank)
					exp.pixel = model[(v * int'(timing_pkg::v_delta)) >> timing_pkg::delta_precision]
						[(h * int'(timing_pkg::h_delta)) >> timing_pkg::delta_precision];
				else
					exp.pixel = tc.blank_rgb;
				assert (video_out === exp)
					else stop_on_error($sformatf("output x %0d y %0d got %h expected %h",
						h, v, video_out, exp));
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rst = 1'b1;
		source_in = '0;
		pixel_strobe = 1'b0;
		repeat (5) @(posedge pixel_clk);
		@(negedge pixel_clk);
		rst = 1'b0;
		// Pipeline still empty, all flags low
		assert (video_out === '0)
			else stop_on_error($sformatf("video_out %h after reset", video_out));
		@(negedge pixel_clk);
		assert (video_out === '0)
			else stop_on_error($sformatf("video_out %h one cycle after reset", video_out));
		for (int i = 0; i < num_cases; i++) begin
			send_frame(cases[i]);
			wait_vblank_fall();
			check_frame(cases[i]);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: sim/upscaler_properties.sv
module upscaler_properties (
	input logic                  pixel_clk,
	input logic                  rst,
	input video_pkg::video_t     source_in,
	input logic                  pixel_strobe,
	input video_pkg::video_t     video_out,
	input logic                  wr_en,
	input timing_pkg::src_addr_t wr_addr
);

	// Next write address expected from the capture side
	timing_pkg::src_addr_t next_wr_addr;

	// Restarts at each strobed source vblank, then steps once per write
	always_ff @(posedge pixel_clk) begin
		if (rst)
			next_wr_addr <= '0;
		else if (pixel_strobe && source_in.vblank)
			next_wr_addr <= '0;
		else if (wr_en)
			next_wr_addr <= wr_addr + 1'b1;
	end

	// Sync pulses sit inside their blanking intervals
	assert property (@(posedge pixel_clk) disable iff (rst)
		video_out.hsync |-> video_out.hblank)
		else $error("hsync high outside hblank");

	assert property (@(posedge pixel_clk) disable iff (rst)
		video_out.vsync |-> video_out.vblank)
		else $error("vsync high outside vblank");

	// Black during any blanking
	assert property (@(posedge pixel_clk) disable iff (rst)
		(video_out.hblank || video_out.vblank) |-> (video_out.pixel == '0))
		else $error("RGB not zero during blanking");

	// Capture side fills the frame store in raster order from the top
	assert property (@(posedge pixel_clk) disable iff (rst)
		wr_en |-> (wr_addr == next_wr_addr))
		else $error("frame store write address out of raster order");

endmodule

bind upscaler_top upscaler_properties props_i (
	.pixel_clk    (pixel_clk),
	.rst          (rst),
	.source_in    (source_in),
	.pixel_strobe (pixel_strobe),
	.video_out    (video_out),
	.wr_en        (wr_en),
	.wr_addr      (wr_addr)
);

// File: verilog/upscaler_top.sv
module upscaler_top (
	input  logic              pixel_clk,
	input  logic              rst,
	// Low resolution source, one pixel per strobe
	input  video_pkg::video_t source_in,
	input  logic              pixel_strobe,
	// Upscaled raster
	output video_pkg::video_t video_out
);

	// Capture to frame store
	logic                  wr_en;
	timing_pkg::src_addr_t wr_addr;
	video_pkg::pixel_t     wr_pixel;
	// Frame store read side
	timing_pkg::src_addr_t rd_addr;
	video_pkg::pixel_t     rd_pixel;
	// Output raster, raw and one cycle late
	timing_pkg::raster_t   raster;
	timing_pkg::raster_t   raster_d;

	////////////////////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////////////////////

	source_capture capture_i (
		.pixel_clk    (pixel_clk),
		.rst          (rst),
		.source_in    (source_in),
		.pixel_strobe (pixel_strobe),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_pixel     (wr_pixel)
	);

	////////////////////////////////////////////////////////////////////////////
	// Processing
	////////////////////////////////////////////////////////////////////////////

	frame_store store_i (
		.pixel_clk (pixel_clk),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_pixel  (wr_pixel),
		.rd_addr   (rd_addr),
		.rd_pixel  (rd_pixel)
	);

	scale_address_gen scale_i (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.raster    (raster),
		.rd_addr   (rd_addr),
		.raster_d  (raster_d)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output side
	////////////////////////////////////////////////////////////////////////////

	vga_timing_gen timing_i (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.raster    (raster)
	);

	// Three cycles from raster to video_out
	pixel_output output_i (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.raster_d  (raster_d),
		.rd_pixel  (rd_pixel),
		.video_out (video_out)
	);

endmodule

// File: verilog/pixel_output.sv
module pixel_output (
	input  logic                pixel_clk,
	input  logic                rst,
	input  timing_pkg::raster_t raster_d,
	input  video_pkg::pixel_t   rd_pixel,
	output video_pkg::video_t   video_out
);

	// Timing held one more cycle to meet the frame store read data
	timing_pkg::raster_t raster_q;

	always_ff @(posedge pixel_clk) begin
		if (rst)
			raster_q <= '0;
		else
			raster_q <= raster_d;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	// Black outside the active area
	always_ff @(posedge pixel_clk) begin
		if (rst) begin
			video_out <= '0;
		end else begin
			if (raster_q.active)
				video_out.pixel <= rd_pixel;
			else
				video_out.pixel <= '0;
			// Flags pass straight through, still aligned with the pixel
			video_out.hsync <= raster_q.hsync;
			video_out.vsync <= raster_q.vsync;
			video_out.hblank <= raster_q.hblank;
			video_out.vblank <= raster_q.vblank;
		end
	end

endmodule

// File: verilog/scale_address_gen.sv
module scale_address_gen (
	input  logic                  pixel_clk,
	input  logic                  rst,
	input  timing_pkg::raster_t   raster,
	output timing_pkg::src_addr_t rd_addr,
	output timing_pkg::raster_t   raster_d
);

	// Source position in Q12, integer part above delta_precision
	logic [timing_pkg::acc_width-1:0] h_acc;
	logic [timing_pkg::acc_width-1:0] v_acc;
	// Integer parts, source column and row
	logic [timing_pkg::src_col_width-1:0] h_int;
	logic [timing_pkg::src_row_width-1:0] v_int;
	// Last active pixel of a line
	logic line_end;

	assign h_int = h_acc[timing_pkg::delta_precision +: timing_pkg::src_col_width];
	assign v_int = v_acc[timing_pkg::delta_precision +: timing_pkg::src_row_width];
	assign line_end = raster.active && (raster.x == timing_pkg::out_h_active - 1);

	////////////////////////////////////////////////////////////////////////////
	// Step accumulators
	////////////////////////////////////////////////////////////////////////////

	// Accumulators hold the step sum for the pixel on raster this cycle
	always_ff @(posedge pixel_clk) begin
		if (rst) begin
			h_acc <= '0;
			v_acc <= '0;
		end else begin
			// Horizontal, zero through hblank so each line starts at column 0
			if (raster.hblank)
				h_acc <= '0;
			else if (raster.active)
				h_acc <= h_acc + timing_pkg::h_delta;

			// Vertical, one step per finished active line
			if (raster.vblank)
				v_acc <= '0;
			else if (line_end)
				v_acc <= v_acc + timing_pkg::v_delta;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address and timing stage
	////////////////////////////////////////////////////////////////////////////

	// Nearest pixel, truncated integer parts
	always_ff @(posedge pixel_clk) begin
		rd_addr <= timing_pkg::src_addr_t'(v_int) *
			timing_pkg::src_addr_t'(timing_pkg::src_width) +
			timing_pkg::src_addr_t'(h_int);
	end

	// Timing travels with the address
	always_ff @(posedge pixel_clk) begin
		if (rst)
			raster_d <= '0;
		else
			raster_d <= raster;
	end

endmodule

// File: verilog/vga_timing_gen.sv
module vga_timing_gen (
	input  logic                pixel_clk,
	input  logic                rst,
	output timing_pkg::raster_t raster
);

	// Raster position, active area starts at 0,0
	logic [timing_pkg::out_x_width-1:0] h_count;
	logic [timing_pkg::out_y_width-1:0] v_count;
	// Last cycle of line and last line of frame
	logic h_last;
	logic v_last;

	assign h_last = (h_count == timing_pkg::out_h_total - 1);
	assign v_last = (v_count == timing_pkg::out_v_total - 1);

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////

	// Free running, one pixel per clock
	always_ff @(posedge pixel_clk) begin
		if (rst) begin
			h_count <= '0;
			v_count <= '0;
		end else begin
			if (h_last) begin
				h_count <= '0;
				if (v_last)
					v_count <= '0;
				else
					v_count <= v_count + 1'b1;
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	// Line layout is active, front porch, sync, back porch
	always_comb begin
		raster.x = h_count;
		raster.y = v_count;
		// Blanking covers both porches and sync
		raster.hblank = (h_count >= timing_pkg::out_h_active);
		raster.vblank = (v_count >= timing_pkg::out_v_active);
		// Syncs active high
		raster.hsync = (h_count >= timing_pkg::out_h_sync_start) &&
			(h_count < timing_pkg::out_h_sync_end);
		raster.vsync = (v_count >= timing_pkg::out_v_sync_start) &&
			(v_count < timing_pkg::out_v_sync_end);
		raster.active = !raster.hblank && !raster.vblank;
	end

endmodule

// File: verilog/frame_store.sv
module frame_store (
	input  logic                  pixel_clk,
	// Write port from the capture side
	input  logic                  wr_en,
	input  timing_pkg::src_addr_t wr_addr,
	input  video_pkg::pixel_t     wr_pixel,
	// Read port from the address generator
	input  timing_pkg::src_addr_t rd_addr,
	output video_pkg::pixel_t     rd_pixel
);

	// One word per source pixel
	localparam int depth = timing_pkg::src_width * timing_pkg::src_height;

	video_pkg::pixel_t mem [depth];

	////////////////////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////////////////////

	// Capture side only writes addresses inside the frame
	always_ff @(posedge pixel_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_pixel;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////////////////////

	// Data one cycle after the address
	// Same-address read during a write returns the old word
	always_ff @(posedge pixel_clk) begin
		rd_pixel <= mem[rd_addr];
	end

endmodule

// File: verilog/source_capture.sv
module source_capture (
	input  logic                 pixel_clk,
	input  logic                 rst,
	input  video_pkg::video_t    source_in,
	input  logic                 pixel_strobe,
	output logic                 wr_en,
	output timing_pkg::src_addr_t wr_addr,
	output video_pkg::pixel_t    wr_pixel
);

	// Source position, one spare bit so counts saturate past the edge
	logic [timing_pkg::src_col_width:0] col;
	logic [timing_pkg::src_row_width:0] row;
	// Previous strobed sample was an active pixel
	logic prev_active;
	// Current position lies inside the stored frame
	logic in_frame;

	assign in_frame = (col < timing_pkg::src_width) && (row < timing_pkg::src_height);

	////////////////////////////////////////////////////////////////////////////
	// Position tracking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pixel_clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
			prev_active <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			// Write pulse lasts one cycle
			wr_en <= 1'b0;
			if (pixel_strobe) begin
				if (source_in.vblank) begin
					// Top of frame
					col <= '0;
					row <= '0;
					prev_active <= 1'b0;
				end else if (source_in.hblank) begin
					col <= '0;
					// First blank sample after a line of pixels
					if (prev_active && (row != timing_pkg::src_height))
						row <= row + 1'b1;
					prev_active <= 1'b0;
				end else begin
					// Active pixel, extra columns or rows are dropped
					wr_en <= in_frame;
					if (col != timing_pkg::src_width)
						col <= col + 1'b1;
					prev_active <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Write payload
	////////////////////////////////////////////////////////////////////////////

	// Address and pixel captured with the strobe, used only with wr_en
	always_ff @(posedge pixel_clk) begin
		if (pixel_strobe) begin
			wr_addr <= timing_pkg::src_addr_t'(row) *
				timing_pkg::src_addr_t'(timing_pkg::src_width) +
				timing_pkg::src_addr_t'(col);
			wr_pixel <= source_in.pixel;
		end
	end

endmodule

// File: verilog/timing_pkg.sv
package timing_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Source frame
	////////////////////////////////////////////////////////////////////////////

	// Active source size
	localparam int src_width      = 16;
	localparam int src_height     = 8;
	// Counter widths for column and row
	localparam int src_col_width  = 4;
	localparam int src_row_width  = 3;
	// Frame store address, row * src_width + column
	localparam int src_addr_width = 7;
	typedef logic [src_addr_width-1:0] src_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// Output raster
	////////////////////////////////////////////////////////////////////////////

	// Horizontal, 40 cycles per line
	localparam int out_h_active     = 32;
	localparam int out_h_front      = 2;
	localparam int out_h_sync       = 4;
	localparam int out_h_back       = 2;
	localparam int out_h_total      = out_h_active + out_h_front + out_h_sync + out_h_back;
	localparam int out_h_sync_start = out_h_active + out_h_front;
	localparam int out_h_sync_end   = out_h_sync_start + out_h_sync;

	// Vertical, 20 lines per frame
	localparam int out_v_active     = 16;
	localparam int out_v_front      = 1;
	localparam int out_v_sync       = 2;
	localparam int out_v_back       = 1;
	localparam int out_v_total      = out_v_active + out_v_front + out_v_sync + out_v_back;
	localparam int out_v_sync_start = out_v_active + out_v_front;
	localparam int out_v_sync_end   = out_v_sync_start + out_v_sync;

	// Position widths
	localparam int out_x_width = 6;
	localparam int out_y_width = 5;

	////////////////////////////////////////////////////////////////////////////
	// Scaling steps
	////////////////////////////////////////////////////////////////////////////

	// Fractional bits of the accumulators
	localparam int delta_precision = 12;
	// Room for a full line of steps
	localparam int acc_width = delta_precision + out_x_width;
	// Source pixels per output pixel, Q12
	localparam logic [acc_width-1:0] h_delta =
		acc_width'((src_width << delta_precision) / out_h_active);
	localparam logic [acc_width-1:0] v_delta =
		acc_width'((src_height << delta_precision) / out_v_active);

	// Output raster state for one cycle
	typedef struct packed {
		logic                   hsync;
		logic                   vsync;
		logic                   hblank;
		logic                   vblank;
		logic                   active;
		logic [out_x_width-1:0] x;
		logic [out_y_width-1:0] y;
	} raster_t;

endpackage

// File: verilog/video_pkg.sv
package video_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Colour
	////////////////////////////////////////////////////////////////////////////

	// Bits per colour component
	localparam int component_depth = 4;

	// One RGB pixel, 12 bits
	typedef struct packed {
		logic [component_depth-1:0] red;
		logic [component_depth-1:0] green;
		logic [component_depth-1:0] blue;
	} pixel_t;

	////////////////////////////////////////////////////////////////////////////
	// Video stream
	////////////////////////////////////////////////////////////////////////////

	// Pixel plus sync and blank flags, all active high
	// Used for both the source input and the upscaled output
	typedef struct packed {
		pixel_t pixel;
		logic   hsync;
		logic   vsync;
		logic   hblank;
		logic   vblank;
	} video_t;

endpackage
